//--- hw/pixel_pkg.sv
package pixel_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////////////

    // integer world units
    localparam int COORD_W = 24;
    // hit distance, unsigned Q8.8
    localparam int T_W     = 16;
    localparam int T_FRAC  = 8;
    localparam int CHAN_W  = 16;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef enum logic {
        BLUE,
        RED
    } block_color_e;

    typedef enum logic [2:0] {
        UP,
        RIGHT,
        DOWN,
        LEFT,
        ANY
    } arrow_dir_e;

    typedef struct packed {
        vec3_t        pos;
        block_color_e color;
        arrow_dir_e   dir;
    } block_t;

    // input record, one per ray hit
    typedef struct packed {
        vec3_t          ray;
        logic [T_W-1:0] t;
        block_t         block;
    } ray_hit_t;

    typedef struct packed {
        vec3_t  scaled;
        vec3_t  point;
        block_t block;
    } hit_t;

    typedef struct packed {
        logic [CHAN_W-1:0] r;
        logic [CHAN_W-1:0] g;
        logic [CHAN_W-1:0] b;
    } rgb_t;

    //////////////////////////////////////////////////////////////////////////////
    // scene constants
    //////////////////////////////////////////////////////////////////////////////

    localparam vec3_t EYE = '{x: 1800, y: 1800, z: -300};

    localparam int MAX_LIGHTS = 3;

    localparam vec3_t LIGHT_POS [MAX_LIGHTS] = '{
        '{x: 1400, y: 1800, z: 100},
        '{x: 1800, y: 1800, z: 100},
        '{x: 2200, y: 1800, z: 100}
    };

    // Q0.8 intensities, inner index is x, y, z
    localparam logic [7:0] LIGHT_GAIN [MAX_LIGHTS][3] = '{
        '{8'd64,  8'd128, 8'd64},
        '{8'd192, 8'd128, 8'd192},
        '{8'd64,  8'd128, 8'd64}
    };

    localparam int LAMBERT_SHIFT = 10;

    // arrow geometry on the block top face
    localparam vec3_t GRID_ORIGIN = '{x: 1800, y: 1800, z: 0};
    localparam int    TOP_HEIGHT  = 200;
    localparam int    ARROW_HALF  = 80;

endpackage

//--- hw/hit_point_calc.sv
module hit_point_calc
    import pixel_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     valid_in,
    input  ray_hit_t hit_in,
    output hit_t     hit,
    output logic     hit_valid
);

    localparam int PROD_W = COORD_W + T_W + 1;

    logic signed [T_W:0]      t_s;
    logic signed [PROD_W-1:0] prod_x, prod_y, prod_z;
    vec3_t                    s1_scaled;
    block_t                   s1_block;
    logic                     s1_valid;

    // t is unsigned, so a zero sign bit goes on top
    assign t_s    = $signed({1'b0, hit_in.t});
    assign prod_x = hit_in.ray.x * t_s;
    assign prod_y = hit_in.ray.y * t_s;
    assign prod_z = hit_in.ray.z * t_s;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid  <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            s1_valid  <= valid_in;
            hit_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        // stage 1, drop the fraction bits of t
        s1_scaled.x <= prod_x[T_FRAC +: COORD_W];
        s1_scaled.y <= prod_y[T_FRAC +: COORD_W];
        s1_scaled.z <= prod_z[T_FRAC +: COORD_W];
        s1_block    <= hit_in.block;
        // stage 2, hit point from the eye
        hit.scaled  <= s1_scaled;
        hit.point.x <= EYE.x + s1_scaled.x;
        hit.point.y <= EYE.y + s1_scaled.y;
        hit.point.z <= EYE.z + s1_scaled.z;
        hit.block   <= s1_block;
    end

endmodule

//--- hw/arrow_test.sv
module arrow_test
    import pixel_pkg::*;
(
    input  logic clk_in,
    input  logic rst_in,
    input  hit_t hit,
    input  logic hit_valid,
    output logic arrow,
    output logic arrow_valid
);

    // headroom so sums of two coordinates never wrap
    localparam int W = COORD_W + 2;

    typedef struct packed {
        logic on_top;
        logic in_a;
        logic in_c;
        logic in_bounds;
        logic x_lt;
        logic y_lt;
    } arrow_flags_t;

    logic signed [W-1:0] sx, sy, sz;
    logic signed [W-1:0] nx, ny, bz;
    arrow_flags_t        flags;
    arrow_flags_t        s1_flags;
    arrow_dir_e          s1_dir;
    logic                s1_valid;

    assign sx = hit.scaled.x;
    assign sy = hit.scaled.y;
    assign sz = hit.scaled.z;
    // block position relative to the grid origin
    assign nx = hit.block.pos.x - GRID_ORIGIN.x;
    assign ny = hit.block.pos.y - GRID_ORIGIN.y;
    assign bz = hit.block.pos.z;

    //////////////////////////////////////////////////////////////////////////////
    // stage 1, region and bounds compares
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        flags.on_top    = (sz - bz - TOP_HEIGHT) <= 0;
        // the two diagonals split the face into four triangles
        flags.in_a      = (sy + sx) < (ny + nx);
        flags.in_c      = (sy - sx) < (ny - nx);
        flags.in_bounds = (sx > nx - ARROW_HALF) && (sx < nx + ARROW_HALF) &&
                          (sy > ny - ARROW_HALF) && (sy < ny + ARROW_HALF);
        flags.x_lt      = sx < nx;
        flags.y_lt      = sy < ny;
    end

    always_ff @(posedge clk_in) begin
        s1_flags <= flags;
        s1_dir   <= hit.block.dir;
    end

    //////////////////////////////////////////////////////////////////////////////
    // stage 2, direction rule
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid    <= 1'b0;
            arrow_valid <= 1'b0;
        end else begin
            s1_valid    <= hit_valid;
            arrow_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        case (s1_dir)
            UP:      arrow <= s1_flags.y_lt && s1_flags.in_a && s1_flags.in_c;
            RIGHT:   arrow <= s1_flags.x_lt && !s1_flags.in_a && s1_flags.in_c;
            DOWN:    arrow <= s1_flags.y_lt && !s1_flags.in_a && !s1_flags.in_c;
            // LEFT and ANY share one triangle
            default: arrow <= s1_flags.x_lt && s1_flags.in_a && !s1_flags.in_c;
        endcase
        if (!(s1_flags.on_top && s1_flags.in_bounds)) begin
            arrow <= 1'b0;
        end
    end

endmodule

//--- hw/lambert_shade.sv
module lambert_shade
    import pixel_pkg::*;
#(
    parameter int N_LIGHTS = MAX_LIGHTS
) (
    input  logic clk_in,
    input  logic rst_in,
    input  hit_t hit,
    input  logic hit_valid,
    output rgb_t shade,
    output logic shade_valid
);

    localparam int W  = COORD_W + 1;
    localparam int DW = 2 * W + 2;
    localparam int TW = DW - 1 + 8;
    localparam int SW = TW + 2;
    localparam logic [CHAN_W-1:0] CHAN_MAX = '1;

    typedef struct packed {
        logic signed [W-1:0] x;
        logic signed [W-1:0] y;
        logic signed [W-1:0] z;
    } wvec_t;

    wvec_t                s1_normal;
    wvec_t                s1_light [N_LIGHTS];
    block_color_e         s1_color, s2_color;
    logic                 s1_valid, s2_valid;
    logic signed [DW-1:0] dot [N_LIGHTS];
    logic [DW-2:0]        s2_dot [N_LIGHTS];
    logic [TW-1:0]        term [N_LIGHTS];
    logic [SW-1:0]        sum;
    logic [1:0]           chan;
    logic [CHAN_W-1:0]    kept;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            shade_valid <= 1'b0;
        end else begin
            s1_valid    <= hit_valid;
            s2_valid    <= s1_valid;
            shade_valid <= s2_valid;
        end
    end

    // stage 1, surface vector and one vector per light
    always_ff @(posedge clk_in) begin
        s1_normal.x <= hit.point.x - hit.block.pos.x;
        s1_normal.y <= hit.point.y - hit.block.pos.y;
        s1_normal.z <= hit.point.z - hit.block.pos.z;
        for (int i = 0; i < N_LIGHTS; i++) begin
            s1_light[i].x <= LIGHT_POS[i].x - hit.point.x;
            s1_light[i].y <= LIGHT_POS[i].y - hit.point.y;
            s1_light[i].z <= LIGHT_POS[i].z - hit.point.z;
        end
        s1_color <= hit.block.color;
    end

    always_comb begin
        for (int i = 0; i < N_LIGHTS; i++) begin
            dot[i] = s1_normal.x * s1_light[i].x +
                     s1_normal.y * s1_light[i].y +
                     s1_normal.z * s1_light[i].z;
        end
    end

    // stage 2, lights behind the surface contribute nothing
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < N_LIGHTS; i++) begin
            s2_dot[i] <= (dot[i] < 0) ? '0 : dot[i][DW-2:0];
        end
        s2_color <= s1_color;
    end

    // blue lives in x, red in z, g is never lit
    always_comb begin
        chan = (s2_color == BLUE) ? 2'd0 : 2'd2;
        sum  = '0;
        for (int i = 0; i < N_LIGHTS; i++) begin
            term[i] = (s2_dot[i] * LIGHT_GAIN[i][chan]) >> (8 + LAMBERT_SHIFT);
            sum     = sum + term[i];
        end
        kept = (sum > CHAN_MAX) ? CHAN_MAX : sum[CHAN_W-1:0];
    end

    // stage 3
    always_ff @(posedge clk_in) begin
        shade.r <= (s2_color == BLUE) ? kept : '0;
        shade.g <= '0;
        shade.b <= (s2_color == RED) ? kept : '0;
    end

endmodule

//--- hw/pixel_select.sv
module pixel_select
    import pixel_pkg::*;
(
    input  logic clk_in,
    input  logic rst_in,
    input  logic arrow,
    input  logic arrow_valid,
    input  rgb_t shade,
    input  logic shade_valid,
    output rgb_t rgb_out,
    output logic rgb_valid
);

    logic              arrow_q;
    logic [CHAN_W-1:0] max_rg;
    logic [CHAN_W-1:0] max_rgb;

    // arrow side finishes one cycle ahead of the shade
    always_ff @(posedge clk_in) begin
        if (arrow_valid) begin
            arrow_q <= arrow;
        end
    end

    assign max_rg  = (shade.r > shade.g) ? shade.r : shade.g;
    assign max_rgb = (max_rg > shade.b) ? max_rg : shade.b;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_out   <= '0;
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= shade_valid;
            if (shade_valid) begin
                if (arrow_q) begin
                    // arrow drawn grey at the brightest channel
                    rgb_out.r <= max_rgb;
                    rgb_out.g <= max_rgb;
                    rgb_out.b <= max_rgb;
                end else begin
                    rgb_out <= shade;
                end
            end
        end
    end

endmodule

//--- hw/pixel_color.sv
module pixel_color
    import pixel_pkg::*;
#(
    parameter int N_LIGHTS = 3
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     valid_in,
    input  ray_hit_t hit_in,
    output rgb_t     rgb_out,
    output logic     rgb_valid
);

    hit_t hit;
    logic hit_valid;
    logic arrow;
    logic arrow_valid;
    rgb_t shade;
    logic shade_valid;

    // 2 cycles, feeds both branches
    hit_point_calc u_hit (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .valid_in (valid_in),
        .hit_in   (hit_in),
        .hit      (hit),
        .hit_valid(hit_valid)
    );

    arrow_test u_arrow (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .hit        (hit),
        .hit_valid  (hit_valid),
        .arrow      (arrow),
        .arrow_valid(arrow_valid)
    );

    lambert_shade #(
        .N_LIGHTS(N_LIGHTS)
    ) u_shade (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .hit        (hit),
        .hit_valid  (hit_valid),
        .shade      (shade),
        .shade_valid(shade_valid)
    );

    // output register, six cycles after valid_in
    pixel_select u_select (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .arrow      (arrow),
        .arrow_valid(arrow_valid),
        .shade      (shade),
        .shade_valid(shade_valid),
        .rgb_out    (rgb_out),
        .rgb_valid  (rgb_valid)
    );

endmodule

//--- bench/pixel_color_asserts.sv
module pixel_color_asserts
    import pixel_pkg::*;
(
    input logic clk_in,
    input logic rst_in,
    input logic valid_in,
    input rgb_t rgb_out,
    input logic rgb_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // strobe timing
    ////////////////////////////////////////////////////////////////////////////

    a_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_in |-> ##6 rgb_valid)
    else begin
        $error("rgb_valid missing six cycles after valid_in");
        fail_count++;
    end

    // no output without a matching input
    a_no_spurious: assert property (@(posedge clk_in) disable iff (rst_in)
        rgb_valid |-> $past(valid_in, 6))
    else begin
        $error("rgb_valid without valid_in six cycles earlier");
        fail_count++;
    end

    a_reset_quiet: assert property (@(posedge clk_in)
        rst_in |=> (!rgb_valid && rgb_out == '0))
    else begin
        $error("outputs active during reset");
        fail_count++;
    end

    a_valid_known: assert property (@(posedge clk_in) disable iff (rst_in)
        !$isunknown(rgb_valid))
    else begin
        $error("rgb_valid is unknown");
        fail_count++;
    end

endmodule

//--- bench/pixel_color_tb.sv
module pixel_color_tb
    import pixel_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_LIGHTS     = 3;
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 3;
    localparam int LATENCY      = 6;
    localparam int N_RANDOM     = 300;
    localparam int N_FACE       = 9;
    localparam int N_SAT        = 4;
    localparam int N_GAPPED     = 200;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_RANDOM + 5 * N_FACE + N_SAT + N_GAPPED;

    // offsets from the block center on the top face, last row sits above the face
    localparam int OFF_X [N_FACE] = '{0, 40, -40, 10, 0, 100, -79, 30, 0};
    localparam int OFF_Y [N_FACE] = '{-40, -10, 10, 40, 0, 0, -5, -60, -40};
    localparam int OFF_Z [N_FACE] = '{1000, 1000, 1000, 1000, 1000, 1000, 1000, 1000, 1300};

    typedef struct {
        int   due;
        rgb_t pix;
    } expect_t;

    logic     clk_in;
    logic     rst_in;
    logic     valid_in;
    ray_hit_t hit_in;
    rgb_t     rgb_out;
    logic     rgb_valid;

    int       cyc = 0;
    logic     seen_output = 1'b0;
    expect_t  exp_q [$];
    expect_t  head;

    pixel_color #(
        .N_LIGHTS(N_LIGHTS)
    ) u_pixel_color (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .valid_in (valid_in),
        .hit_in   (hit_in),
        .rgb_out  (rgb_out),
        .rgb_valid(rgb_valid)
    );

    bind pixel_color pixel_color_asserts u_asserts (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .valid_in (valid_in),
        .rgb_out  (rgb_out),
        .rgb_valid(rgb_valid)
    );

    always #(PERIOD / 2) clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("ERROR at %0d ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, wide integer math
    ////////////////////////////////////////////////////////////////////////////

    function automatic rgb_t expected_pixel(input ray_hit_t h, output logic arrow_hit);
        longint s [3];
        longint p [3];
        longint lv [3];
        longint pos [3];
        longint nx, ny, dot, sum, top;
        logic   on_top, in_a, in_c, in_b, x_lt, y_lt;
        int     g;
        rgb_t   pix;
        pos[0] = longint'($signed(h.block.pos.x));
        pos[1] = longint'($signed(h.block.pos.y));
        pos[2] = longint'($signed(h.block.pos.z));
        s[0]   = (longint'($signed(h.ray.x)) * longint'(h.t)) >>> T_FRAC;
        s[1]   = (longint'($signed(h.ray.y)) * longint'(h.t)) >>> T_FRAC;
        s[2]   = (longint'($signed(h.ray.z)) * longint'(h.t)) >>> T_FRAC;
        p[0]   = longint'($signed(EYE.x)) + s[0];
        p[1]   = longint'($signed(EYE.y)) + s[1];
        p[2]   = longint'($signed(EYE.z)) + s[2];
        // arrow region on the top face
        nx     = pos[0] - longint'($signed(GRID_ORIGIN.x));
        ny     = pos[1] - longint'($signed(GRID_ORIGIN.y));
        top    = s[2] - pos[2] - TOP_HEIGHT;
        on_top = top <= 0;
        in_a   = (s[1] + s[0]) < (ny + nx);
        in_c   = (s[1] - s[0]) < (ny - nx);
        in_b   = (s[0] > nx - ARROW_HALF) && (s[0] < nx + ARROW_HALF) &&
                 (s[1] > ny - ARROW_HALF) && (s[1] < ny + ARROW_HALF);
        x_lt   = s[0] < nx;
        y_lt   = s[1] < ny;
        case (h.block.dir)
            UP:      arrow_hit = y_lt && in_a && in_c;
            RIGHT:   arrow_hit = x_lt && !in_a && in_c;
            DOWN:    arrow_hit = y_lt && !in_a && !in_c;
            default: arrow_hit = x_lt && in_a && !in_c;
        endcase
        arrow_hit = arrow_hit && on_top && in_b;
        // lambert, blue uses the x gain and red the z gain
        g   = (h.block.color == BLUE) ? 0 : 2;
        sum = 0;
        for (int i = 0; i < N_LIGHTS; i++) begin
            lv[0] = longint'($signed(LIGHT_POS[i].x)) - p[0];
            lv[1] = longint'($signed(LIGHT_POS[i].y)) - p[1];
            lv[2] = longint'($signed(LIGHT_POS[i].z)) - p[2];
            dot   = (p[0] - pos[0]) * lv[0] + (p[1] - pos[1]) * lv[1] +
                    (p[2] - pos[2]) * lv[2];
            if (dot < 0) begin
                dot = 0;
            end
            sum += (dot * longint'(LIGHT_GAIN[i][g])) >> (8 + LAMBERT_SHIFT);
        end
        if (sum > 65535) begin
            sum = 65535;
        end
        pix.r = (h.block.color == BLUE) ? sum[CHAN_W-1:0] : '0;
        pix.g = '0;
        pix.b = (h.block.color == RED) ? sum[CHAN_W-1:0] : '0;
        // g is always zero, so the brightest channel is r or b
        if (arrow_hit) begin
            pix.g = (pix.r > pix.b) ? pix.r : pix.b;
            pix.r = pix.g;
            pix.b = pix.g;
        end
        return pix;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic ray_hit_t random_hit();
        ray_hit_t h;
        h.ray.x       = int'($urandom_range(0, 1023)) - 512;
        h.ray.y       = int'($urandom_range(0, 1023)) - 512;
        h.ray.z       = int'($urandom_range(0, 1023)) - 512;
        h.t           = $urandom_range(0, 2047);
        h.block.pos.x = 1200 + int'($urandom_range(0, 1200));
        h.block.pos.y = 1200 + int'($urandom_range(0, 1200));
        h.block.pos.z = int'($urandom_range(0, 600)) - 200;
        h.block.color = block_color_e'($urandom_range(0, 1));
        h.block.dir   = arrow_dir_e'($urandom_range(0, 4));
        return h;
    endfunction

    // block center at grid offset (100, 100), t of 1.0 so scaled equals the ray
    function automatic ray_hit_t face_hit(input arrow_dir_e dir, input block_color_e color,
                                          input int dx, input int dy, input int sz);
        ray_hit_t h;
        h.ray.x       = 100 + dx;
        h.ray.y       = 100 + dy;
        h.ray.z       = sz;
        h.t           = 16'd256;
        h.block.pos   = '{x: 1900, y: 1900, z: 1000};
        h.block.color = color;
        h.block.dir   = dir;
        return h;
    endfunction

    task automatic send_item(input logic v, input ray_hit_t h, output rgb_t pix,
                             output logic arrow_hit);
        expect_t e;
        valid_in  = v;
        hit_in    = h;
        pix       = expected_pixel(h, arrow_hit);
        if (v) begin
            e.due = cyc + LATENCY;
            e.pix = pix;
            exp_q.push_back(e);
        end
        @(posedge clk_in);
        #5;
    endtask

    // output checker, sampled mid-cycle
    always @(negedge clk_in) begin
        if (cyc >= 1) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                head = exp_q.pop_front();
                check_value("rgb_valid", rgb_valid, 1'b1);
                check_value("rgb_out.r", rgb_out.r, head.pix.r);
                check_value("rgb_out.g", rgb_out.g, head.pix.g);
                check_value("rgb_out.b", rgb_out.b, head.pix.b);
                seen_output = 1'b1;
            end else begin
                check_value("rgb_valid", rgb_valid, 1'b0);
                if (!seen_output) begin
                    check_value("rgb_out", rgb_out, '0);
                end
            end
        end
    end

    initial begin
        #((TOTAL_CYCLES + 20) * PERIOD);
        abort_run("watchdog timeout, the run did not finish in time");
    end

    initial begin
        rgb_t     pix;
        logic     arrow_hit;
        ray_hit_t h;
        int       arrows;
        clk_in   = 1'b0;
        rst_in   = 1'b1;
        valid_in = 1'b0;
        hit_in   = '0;
        arrows   = 0;
        void'($urandom(32'h6990));
        repeat (RESET_CYCLES) @(posedge clk_in);
        #5;
        rst_in = 1'b0;

        // back-to-back random stream
        repeat (N_RANDOM) send_item(1'b1, random_hit(), pix, arrow_hit);

        // every direction against the same set of face offsets
        for (int d = 0; d < 5; d++) begin
            for (int k = 0; k < N_FACE; k++) begin
                h = face_hit(arrow_dir_e'(d), block_color_e'(k % 2),
                             OFF_X[k], OFF_Y[k], OFF_Z[k]);
                send_item(1'b1, h, pix, arrow_hit);
                arrows += arrow_hit;
            end
        end
        if (arrows == 0) begin
            abort_run("directed face hits never landed on an arrow");
        end

        // block far below the eye, huge dot products
        for (int k = 0; k < N_SAT; k++) begin
            h             = random_hit();
            h.ray.x       = int'($urandom_range(0, 31)) - 16;
            h.ray.y       = int'($urandom_range(0, 31)) - 16;
            // hit point stays well below every light
            h.ray.z       = int'($urandom_range(0, 255)) - 256;
            h.t           = 16'd256;
            h.block.pos   = '{x: 1800, y: 1800, z: -4000000};
            h.block.color = block_color_e'(k % 2);
            send_item(1'b1, h, pix, arrow_hit);
            if (h.block.color == BLUE) begin
                check_value("saturated r", pix.r, 16'hffff);
            end else begin
                check_value("saturated b", pix.b, 16'hffff);
            end
        end

        // roughly 40% idle cycles
        repeat (N_GAPPED) send_item($urandom_range(0, 99) < 60, random_hit(), pix, arrow_hit);
        valid_in = 1'b0;

        while (exp_q.size() != 0) @(posedge clk_in);
        repeat (2) @(posedge clk_in);
        if (u_pixel_color.u_asserts.fail_count != 0) begin
            abort_run("the bound assertions reported failures");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- filelist.f
hw/pixel_pkg.sv
hw/hit_point_calc.sv
hw/arrow_test.sv
hw/lambert_shade.sv
hw/pixel_select.sv
hw/pixel_color.sv
bench/pixel_color_asserts.sv
bench/pixel_color_tb.sv

//--- Bender.yml
package:
  name: pixel_color

sources:
  - files:
      - hw/pixel_pkg.sv
      - hw/hit_point_calc.sv
      - hw/arrow_test.sv
      - hw/lambert_shade.sv
      - hw/pixel_select.sv
      - hw/pixel_color.sv
  - target: test
    files:
      - bench/pixel_color_asserts.sv
      - bench/pixel_color_tb.sv
